//--- cart_pkg.sv
`default_nettype none

package cart_pkg;

  ////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////

  typedef logic [23:0] snes_addr_t;   // Console bus address
  typedef logic [23:0] mem_addr_t;    // Byte address into ROM/PSRAM
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;    // External memory word
  typedef logic [23:0] mem_mask_t;    // Region size mask

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  localparam int SYNC_DEPTH = 8;      // Control sample shift registers
  localparam int ADDR_DEPTH = 7;      // Address sample pipeline

  // Counter load for one MCU access, ADDR phase is load + 1 cycles
  localparam logic [3:0] ROM_CYCLE_LEN = 4'd7;

  // CPU clock low this long means the console has stopped, 10 us
  localparam logic [17:0] SNES_DEAD_TIMEOUT = 18'd960;

  localparam mem_addr_t SAVERAM_BASE = 24'hE00000;

  // MCU access sequencer states, one-hot
  typedef enum logic [4:0] {
    ST_IDLE        = 5'b00001,
    ST_MCU_RD_ADDR = 5'b00010,
    ST_MCU_RD_END  = 5'b00100,
    ST_MCU_WR_ADDR = 5'b01000,
    ST_MCU_WR_END  = 5'b10000
  } mcu_state_t;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // Raw console pins, asynchronous to CLK2
  typedef struct packed {
    snes_addr_t addr;
    logic       read_n;
    logic       write_n;
    logic       romsel_n;
    logic       cpu_clk;
    byte_t      din;
  } snes_bus_t;

  // Console bus after sampling, read/write/romsel stay active low
  typedef struct packed {
    snes_addr_t addr;
    logic       read;
    logic       write;
    logic       romsel;
    logic       cpu_clk;
    logic       cycle_start;
    logic       pulse_end;
    logic       dead;
    byte_t      din;          // Write data, same latency as the levels
  } snes_ctrl_t;

  typedef struct packed {
    mem_addr_t mem_addr;
    logic      rom_hit;
    logic      is_saveram;
  } map_t;

  typedef struct packed {
    logic      rrq;
    logic      wrq;
    mem_addr_t addr;
    byte_t     dout;
  } mcu_req_t;

  typedef struct packed {
    mem_addr_t mem_addr;
    logic      rd_hit;
    logic      wr_hit;
    logic      we_hit;
  } mcu_port_t;

endpackage

`default_nettype wire

//--- snes_bus_sync.sv
`timescale 1ns/1ps
`default_nettype none

module snes_bus_sync (
  input  logic                 CLK2,
  input  logic                 reset,
  input  cart_pkg::snes_bus_t  snes,
  output cart_pkg::snes_ctrl_t ctrl
);
  import cart_pkg::*;

  logic [SYNC_DEPTH-1:0] read_sr;
  logic [SYNC_DEPTH-1:0] write_sr;
  logic [SYNC_DEPTH-1:0] romsel_sr;
  logic [SYNC_DEPTH-1:0] cpu_clk_sr;
  logic [SYNC_DEPTH-1:0] pulse_sr;
  snes_addr_t            addr_sr [ADDR_DEPTH];
  byte_t                 din_q1;
  byte_t                 din_q2;
  logic                  pulse_in;
  logic                  cpu_clk_f;
  logic [17:0]           dead_cnt;
  logic                  dead;

  // Idle pulse: no read, no write, CPU clock low
  assign pulse_in = snes.read_n & snes.write_n & ~snes.cpu_clk;

  assign cpu_clk_f = cpu_clk_sr[2] & cpu_clk_sr[1];

  ////////////////////////////////////////////////////////////
  // Sample shift registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_sr    <= '1;    // Bus idle
      write_sr   <= '1;
      romsel_sr  <= '1;
      cpu_clk_sr <= '0;
      pulse_sr   <= '1;
    end else begin
      read_sr    <= {read_sr[SYNC_DEPTH-2:0], snes.read_n};
      write_sr   <= {write_sr[SYNC_DEPTH-2:0], snes.write_n};
      romsel_sr  <= {romsel_sr[SYNC_DEPTH-2:0], snes.romsel_n};
      cpu_clk_sr <= {cpu_clk_sr[SYNC_DEPTH-2:0], snes.cpu_clk};
      pulse_sr   <= {pulse_sr[SYNC_DEPTH-2:0], pulse_in};
    end
  end

  // Address and data pipelines
  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes.addr;
    for (int i = 1; i < ADDR_DEPTH; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
    din_q1 <= snes.din;
    din_q2 <= din_q1;
  end

  ////////////////////////////////////////////////////////////
  // Dead console detection
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt <= '0;
      dead     <= 1'b1;     // Assume stopped until a clock is seen
    end else begin
      if (cpu_clk_f) begin
        dead_cnt <= '0;
        dead     <= 1'b0;
      end else begin
        if (dead_cnt != '1) dead_cnt <= dead_cnt + 1'b1;   // Saturate
        if (dead_cnt > SNES_DEAD_TIMEOUT) dead <= 1'b1;
      end
    end
  end

  always_comb begin
    ctrl.addr        = addr_sr[ADDR_DEPTH-1] & addr_sr[ADDR_DEPTH-2];
    ctrl.read        = read_sr[2] & read_sr[1];
    ctrl.write       = write_sr[2] & write_sr[1];
    ctrl.romsel      = romsel_sr[2] & romsel_sr[1];
    ctrl.cpu_clk     = cpu_clk_f;
    ctrl.cycle_start = (cpu_clk_sr[6:1] == 6'b000001);   // CPU clock rise
    ctrl.pulse_end   = (pulse_sr[6:1] == 6'b000011);
    ctrl.dead        = dead;
    ctrl.din         = din_q2;
  end

  // Idle pulse needs CPU clock low on tap 1, a cycle start needs it high
  a_strobes_exclusive: assert property (@(posedge CLK2) disable iff (reset)
    !(ctrl.cycle_start && ctrl.pulse_end));

endmodule

`default_nettype wire

//--- snes_addr_map.sv
`timescale 1ns/1ps
`default_nettype none

module snes_addr_map (
  input  logic                 CLK2,
  input  logic                 reset,
  input  cart_pkg::snes_ctrl_t ctrl,
  input  cart_pkg::mem_mask_t  rom_mask,
  input  cart_pkg::mem_mask_t  saveram_mask,
  output cart_pkg::map_t       map
);
  import cart_pkg::*;

  logic      rom_hit;
  logic      is_saveram;
  mem_addr_t saveram_addr;
  mem_addr_t rom_addr;
  mem_addr_t mem_addr;

  assign rom_hit = ~ctrl.romsel;

  // Banks x70-x7F, lower half of each bank
  assign is_saveram = rom_hit & (&ctrl.addr[22:20]) & ~ctrl.addr[15];

  ////////////////////////////////////////////////////////////
  // Region address generation
  ////////////////////////////////////////////////////////////

  assign saveram_addr = SAVERAM_BASE
                      | ({4'b0000, ctrl.addr[20:16], ctrl.addr[14:0]} & saveram_mask);

  // LoROM, 32 KiB per bank, A15 dropped
  assign rom_addr = {2'b00, ctrl.addr[22:16], ctrl.addr[14:0]} & rom_mask;

  assign mem_addr = is_saveram ? saveram_addr : rom_addr;

  always_ff @(posedge CLK2) begin
    map.mem_addr <= mem_addr;
    if (reset) begin
      map.rom_hit    <= 1'b0;
      map.is_saveram <= 1'b0;
    end else begin
      map.rom_hit    <= rom_hit;
      map.is_saveram <= is_saveram;
    end
  end

endmodule

`default_nettype wire

//--- mcu_access_seq.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_access_seq (
  input  logic                 CLK2,
  input  logic                 reset,
  input  cart_pkg::mcu_req_t   mcu,
  input  cart_pkg::snes_ctrl_t ctrl,
  input  logic                 rom_hit,
  input  cart_pkg::byte_t      rom_byte,
  output cart_pkg::mcu_port_t  port,
  output cart_pkg::byte_t      mcu_din,
  output logic                 mcu_rdy
);
  import cart_pkg::*;

  mcu_state_t state;
  logic [3:0] delay;
  logic       rd_pend;
  logic       wr_pend;
  mem_addr_t  req_addr;
  logic       free_strobe;
  logic       free_slot;
  logic       access_end;
  logic       revive;

  assign access_end = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);
  assign revive     = ctrl.dead & ctrl.cpu_clk;   // Console started again

  ////////////////////////////////////////////////////////////
  // Request latches
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu.rrq) begin    // Read wins over write
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu.wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu.rrq || mcu.wrq) req_addr <= mcu.addr;
  end

  // Non-ROM console cycle leaves the port free
  always_ff @(posedge CLK2) begin
    if (reset) free_strobe <= 1'b0;
    else       free_strobe <= ctrl.cycle_start & ~rom_hit;
  end

  assign free_slot = ctrl.pulse_end | free_strobe;

  ////////////////////////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (revive) begin
      state <= ST_IDLE;      // Abort, pending flag restarts it later
    end else begin
      case (state)
        ST_IDLE: begin
          if ((free_slot || ctrl.dead) && (rd_pend || wr_pend)) begin
            state <= rd_pend ? ST_MCU_RD_ADDR : ST_MCU_WR_ADDR;
            delay <= ROM_CYCLE_LEN;
          end
        end
        ST_MCU_RD_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_MCU_RD_END;
        end
        ST_MCU_WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_MCU_WR_END;
        end
        ST_MCU_RD_END, ST_MCU_WR_END: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Last sample before END holds the settled byte
  always_ff @(posedge CLK2) begin
    if (state == ST_MCU_RD_ADDR) mcu_din <= rom_byte;
  end

  always_comb begin
    port.mem_addr = req_addr;
    port.rd_hit   = (state == ST_MCU_RD_ADDR) || (state == ST_MCU_RD_END);
    port.wr_hit   = (state == ST_MCU_WR_ADDR) || (state == ST_MCU_WR_END);
    port.we_hit   = (state == ST_MCU_WR_ADDR);
  end

  a_state_onehot: assert property (@(posedge CLK2) disable iff (reset)
    $onehot(state));

  // MCU waits for ready before the next request
  a_no_req_busy: assert property (@(posedge CLK2) disable iff (reset)
    (mcu.rrq || mcu.wrq) |-> mcu_rdy);

endmodule

`default_nettype wire

//--- rom_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module rom_port_mux (
  input  cart_pkg::snes_ctrl_t ctrl,
  input  cart_pkg::map_t       map,
  input  cart_pkg::mcu_port_t  port,
  input  cart_pkg::byte_t      mcu_dout,
  input  cart_pkg::rom_word_t  rom_din,
  output cart_pkg::mem_addr_t  rom_addr,
  output cart_pkg::rom_word_t  rom_dout,
  output logic                 rom_dout_en,
  output logic                 rom_we_n,
  output logic                 rom_bhe_n,
  output logic                 rom_ble_n,
  output cart_pkg::byte_t      rom_byte,
  output cart_pkg::byte_t      snes_dout,
  output logic                 snes_dout_en
);
  import cart_pkg::*;

  logic  mcu_hit;
  logic  lane_lo;
  logic  snes_wr;
  byte_t wr_byte;

  assign mcu_hit = port.rd_hit | port.wr_hit;

  ////////////////////////////////////////////////////////////
  // Address and byte lanes
  ////////////////////////////////////////////////////////////

  assign rom_addr = mcu_hit ? port.mem_addr : map.mem_addr;
  assign lane_lo  = rom_addr[0];      // Odd address on the low lane

  assign rom_bhe_n = lane_lo;
  assign rom_ble_n = ~lane_lo;

  assign rom_byte = lane_lo ? rom_din[7:0] : rom_din[15:8];

  assign snes_dout    = rom_byte;
  assign snes_dout_en = ~ctrl.read;

  ////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////

  assign snes_wr = map.rom_hit & ~ctrl.write;

  // Console write has priority over the MCU
  assign wr_byte = snes_wr ? ctrl.din : mcu_dout;

  assign rom_dout    = {wr_byte, wr_byte};    // Lane enables pick the half
  assign rom_dout_en = snes_wr | port.wr_hit;

  always_comb begin
    if (map.rom_hit && map.is_saveram && ctrl.cpu_clk) begin
      rom_we_n = ctrl.write;
    end else if (port.we_hit) begin
      rom_we_n = 1'b0;
    end else begin
      rom_we_n = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- cart_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cart_mem_ctrl (
  input  logic                CLK2,
  input  logic                reset,
  input  cart_pkg::snes_bus_t snes,
  input  cart_pkg::mcu_req_t  mcu,
  input  cart_pkg::mem_mask_t rom_mask,
  input  cart_pkg::mem_mask_t saveram_mask,
  input  cart_pkg::rom_word_t rom_din,
  output cart_pkg::mem_addr_t rom_addr,
  output cart_pkg::rom_word_t rom_dout,
  output logic                rom_dout_en,
  output logic                rom_we_n,
  output logic                rom_bhe_n,
  output logic                rom_ble_n,
  output cart_pkg::byte_t     snes_dout,
  output logic                snes_dout_en,
  output cart_pkg::byte_t     mcu_din,
  output logic                mcu_rdy
);
  import cart_pkg::*;

  snes_ctrl_t ctrl;
  map_t       map;
  mcu_port_t  port;
  byte_t      rom_byte;     // Selected lane, back to the MCU side

  ////////////////////////////////////////////////////////////
  // Console path
  ////////////////////////////////////////////////////////////

  snes_bus_sync i_sync (
    .CLK2  (CLK2),
    .reset (reset),
    .snes  (snes),
    .ctrl  (ctrl)
  );

  snes_addr_map i_map (
    .CLK2         (CLK2),
    .reset        (reset),
    .ctrl         (ctrl),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .map          (map)
  );

  // MCU path
  mcu_access_seq i_seq (
    .CLK2     (CLK2),
    .reset    (reset),
    .mcu      (mcu),
    .ctrl     (ctrl),
    .rom_hit  (map.rom_hit),
    .rom_byte (rom_byte),
    .port     (port),
    .mcu_din  (mcu_din),
    .mcu_rdy  (mcu_rdy)
  );

  rom_port_mux i_mux (
    .ctrl         (ctrl),
    .map          (map),
    .port         (port),
    .mcu_dout     (mcu.dout),
    .rom_din      (rom_din),
    .rom_addr     (rom_addr),
    .rom_dout     (rom_dout),
    .rom_dout_en  (rom_dout_en),
    .rom_we_n     (rom_we_n),
    .rom_bhe_n    (rom_bhe_n),
    .rom_ble_n    (rom_ble_n),
    .rom_byte     (rom_byte),
    .snes_dout    (snes_dout),
    .snes_dout_en (snes_dout_en)
  );

endmodule

`default_nettype wire

//--- tb_cart_vectors.svh
`ifndef TB_CART_VECTORS_SVH
`define TB_CART_VECTORS_SVH

// Columns: operation, console or MCU address, data byte, expected ROM address
// Masks in use: rom_mask 1FFFFF, saveram_mask 01FFFF

localparam int NUM_VEC = 12;

vec_t vectors [NUM_VEC];

task automatic load_vectors();
  vectors[0]  = {OP_SNES_RD, 24'h129ABC, 8'h00, 24'h091ABC};
  vectors[1]  = {OP_SNES_RD, 24'h058001, 8'h00, 24'h028001};
  vectors[2]  = {OP_SNES_RD, 24'hC08123, 8'h00, 24'h000123};  // Bank bit 22 masked off
  vectors[3]  = {OP_SNES_RD, 24'h3FFFFF, 8'h00, 24'h1FFFFF};
  vectors[4]  = {OP_SAVE_WR, 24'h701235, 8'hA5, 24'hE01235};
  vectors[5]  = {OP_SAVE_WR, 24'h710042, 8'h3C, 24'hE08042};
  vectors[6]  = {OP_MCU_RD,  24'h123457, 8'h00, 24'h123457};  // Console dead from here
  vectors[7]  = {OP_MCU_RD,  24'hE01235, 8'h00, 24'hE01235};  // Reads back the save-RAM byte
  vectors[8]  = {OP_REVIVE,  24'h300021, 8'h00, 24'h300021};
  vectors[9]  = {OP_MCU_WR,  24'h123457, 8'h5A, 24'h123457};
  vectors[10] = {OP_MCU_WR,  24'h040000, 8'hC3, 24'h040000};
  vectors[11] = {OP_MCU_RD,  24'h040000, 8'h00, 24'h040000};
endtask

`endif

//--- tb_cart_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cart_mem_ctrl;
  import cart_pkg::*;

  localparam logic [2:0] OP_SNES_RD = 3'd0;
  localparam logic [2:0] OP_SAVE_WR = 3'd1;
  localparam logic [2:0] OP_MCU_RD  = 3'd2;
  localparam logic [2:0] OP_MCU_WR  = 3'd3;
  localparam logic [2:0] OP_REVIVE  = 3'd4;

  typedef struct packed {
    logic [2:0] op;
    logic [23:0] addr;
    byte_t       data;
    mem_addr_t   exp;
  } vec_t;

  `include "tb_cart_vectors.svh"

  localparam int TIMEOUT_CYCLES = NUM_VEC * 40 + int'(SNES_DEAD_TIMEOUT) + 100;

  logic       CLK2;
  logic       reset;
  snes_bus_t  snes;
  mcu_req_t   mcu;
  mem_mask_t  rom_mask;
  mem_mask_t  saveram_mask;
  rom_word_t  rom_din;
  mem_addr_t  rom_addr;
  rom_word_t  rom_dout;
  logic       rom_dout_en;
  logic       rom_we_n;
  logic       rom_bhe_n;
  logic       rom_ble_n;
  byte_t      snes_dout;
  logic       snes_dout_en;
  byte_t      mcu_din;
  logic       mcu_rdy;

  int        errors;
  int        cycle_count;
  int        low_cycles;     // CLK2 cycles with the CPU clock low
  int        half_cnt;
  int        wr_count;
  logic      run_clk;
  rom_word_t lfsr_words [256];
  byte_t     wr_mem [mem_addr_t];

  cart_mem_ctrl i_cart_mem_ctrl (
    .CLK2         (CLK2),
    .reset        (reset),
    .snes         (snes),
    .mcu          (mcu),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .rom_din      (rom_din),
    .rom_addr     (rom_addr),
    .rom_dout     (rom_dout),
    .rom_dout_en  (rom_dout_en),
    .rom_we_n     (rom_we_n),
    .rom_bhe_n    (rom_bhe_n),
    .rom_ble_n    (rom_ble_n),
    .snes_dout    (snes_dout),
    .snes_dout_en (snes_dout_en),
    .mcu_din      (mcu_din),
    .mcu_rdy      (mcu_rdy)
  );

  initial begin
    CLK2 = 1'b0;
    forever #50 CLK2 = ~CLK2;
  end

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
  endfunction

  // LFSR table mixed with the full address
  function automatic rom_word_t fill_word(mem_addr_t a);
    fill_word = lfsr_words[a[8:1]] ^ a[23:8] ^ {a[7:0], a[15:8]};
  endfunction

  // Odd address sits on the low lane
  function automatic byte_t model_byte(mem_addr_t a);
    rom_word_t w;
    w = fill_word({a[23:1], 1'b0});
    if (wr_mem.exists(a)) model_byte = wr_mem[a];
    else                  model_byte = a[0] ? w[7:0] : w[15:8];
  endfunction

  function automatic rom_word_t read_word(mem_addr_t a);
    read_word = {model_byte({a[23:1], 1'b0}), model_byte({a[23:1], 1'b1})};
  endfunction

  initial begin
    logic [31:0] seed;
    seed = 32'h6f6b;
    for (int i = 0; i < 256; i++) begin
      for (int b = 0; b < 16; b++) begin
        seed = lfsr_next(seed);
        lfsr_words[i][b] = seed[0];   // One step per bit
      end
    end
  end

  always @(rom_addr or wr_count) begin
    if (^rom_addr !== 1'bx) rom_din = read_word(rom_addr);
  end

  always @(posedge CLK2) begin
    if (rom_we_n === 1'b0) begin
      if (rom_ble_n === 1'b0) wr_mem[{rom_addr[23:1], 1'b1}] = rom_dout[7:0];
      if (rom_bhe_n === 1'b0) wr_mem[{rom_addr[23:1], 1'b0}] = rom_dout[15:8];
      wr_count = wr_count + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Console CPU clock and watchdog
  ////////////////////////////////////////////////////////////

  // Free-running CPU clock with 6 cycles high and 6 low
  initial begin
    half_cnt = 0;
    forever begin
      @(posedge CLK2);
      #10;
      if (run_clk) begin
        if (half_cnt == 5) begin
          snes.cpu_clk = ~snes.cpu_clk;
          half_cnt = 0;
        end else begin
          half_cnt = half_cnt + 1;
        end
      end else begin
        half_cnt = 0;
      end
    end
  end

  always @(posedge CLK2) begin
    low_cycles <= snes.cpu_clk ? 0 : low_cycles + 1;
  end

  always @(posedge CLK2) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles, the DUT did not finish in time", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic tick();
    @(posedge CLK2);
    #10;
  endtask

  task automatic check_addr(string name, mem_addr_t got, mem_addr_t exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(string name, byte_t got, byte_t exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_dead();
    run_clk      = 1'b0;
    snes.cpu_clk = 1'b0;
    while (low_cycles < int'(SNES_DEAD_TIMEOUT) + 10) tick();
  endtask

  task automatic wait_ready(int max_cycles);
    int n;
    n = 0;
    while (mcu_rdy !== 1'b1 && n < max_cycles) begin
      tick();
      n++;
    end
    if (mcu_rdy !== 1'b1) begin
      $display("MCU ready did not return within %0d cycles at %0t ns", max_cycles, $time);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////

  task automatic snes_read_op(vec_t v);
    snes.addr     = v.addr;
    snes.romsel_n = 1'b0;
    snes.read_n   = 1'b0;
    repeat (10) tick();
    check_addr("rom_addr", rom_addr, v.exp);
    check_bit("rom_bhe_n", rom_bhe_n, v.exp[0]);    // Odd byte on the low lane
    check_bit("rom_ble_n", rom_ble_n, ~v.exp[0]);
    check_byte("snes_dout", snes_dout, model_byte(v.exp));
    check_bit("snes_dout_en", snes_dout_en, 1'b1);
    snes.read_n   = 1'b1;
    snes.romsel_n = 1'b1;
    repeat (3) tick();
  endtask

  task automatic saveram_write_op(vec_t v);
    run_clk       = 1'b0;
    snes.cpu_clk  = 1'b1;
    snes.addr     = v.addr;
    snes.din      = v.data;
    snes.romsel_n = 1'b0;
    repeat (10) tick();    // Let the mapped address settle first
    snes.write_n = 1'b0;
    repeat (4) tick();
    check_addr("rom_addr", rom_addr, v.exp);
    check_bit("rom_we_n", rom_we_n, 1'b0);
    check_bit("rom_dout_en", rom_dout_en, 1'b1);
    check_byte("rom_dout[15:8]", rom_dout[15:8], v.data);
    check_byte("rom_dout[7:0]", rom_dout[7:0], v.data);
    snes.write_n = 1'b1;
    repeat (3) tick();
    snes.romsel_n = 1'b1;
    check_byte("memory byte", model_byte(v.exp), v.data);
    repeat (3) tick();
  endtask

  task automatic mcu_read_op(vec_t v);
    int n;
    logic dead_path;
    dead_path = !run_clk;
    if (dead_path) wait_dead();
    mcu.addr = v.addr;
    mcu.rrq  = 1'b1;
    tick();
    mcu.rrq = 1'b0;
    check_bit("mcu_rdy", mcu_rdy, 1'b0);
    if (dead_path) begin
      n = 0;
      while (mcu_rdy !== 1'b1 && n < 20) begin
        tick();
        n++;
        if (mcu_rdy !== 1'b1) check_addr("rom_addr", rom_addr, v.exp);
      end
      if (n != 10) begin
        $display("MCU ready rose %0d edges after the request, expected 10", n);
        errors++;
      end
    end else begin
      wait_ready(80);
    end
    check_byte("mcu_din", mcu_din, model_byte(v.exp));
  endtask

  task automatic mcu_write_op(vec_t v);
    int n;
    int we_cnt;
    run_clk  = 1'b1;
    mcu.addr = v.addr;
    mcu.dout = v.data;
    mcu.wrq  = 1'b1;
    tick();
    mcu.wrq = 1'b0;
    n = 0;
    we_cnt = 0;
    while (mcu_rdy !== 1'b1 && n < 80) begin
      tick();
      n++;
      if (rom_we_n === 1'b0) begin
        we_cnt++;
        check_addr("rom_addr", rom_addr, v.exp);
        check_bit("rom_dout_en", rom_dout_en, 1'b1);
        check_byte("rom_dout[15:8]", rom_dout[15:8], v.data);
        check_byte("rom_dout[7:0]", rom_dout[7:0], v.data);
      end
    end
    if (mcu_rdy !== 1'b1) begin
      $display("MCU write did not finish at %0t ns", $time);
      errors++;
    end
    if (we_cnt != 8) begin
      $display("Write enable was low for %0d cycles, expected 8", we_cnt);
      errors++;
    end
    check_byte("memory byte", model_byte(v.exp), v.data);
  endtask

  // Console comes back while the read is in its address phase
  task automatic revive_op(vec_t v);
    wait_dead();
    mcu.addr = v.addr;
    mcu.rrq  = 1'b1;
    tick();
    mcu.rrq = 1'b0;
    repeat (3) tick();
    snes.cpu_clk = 1'b1;
    run_clk      = 1'b1;
    // Aborted read still busy when an unbroken one would be done
    repeat (7) tick();
    check_bit("mcu_rdy", mcu_rdy, 1'b0);
    wait_ready(80);
    check_byte("mcu_din", mcu_din, model_byte(v.exp));
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    errors        = 0;
    cycle_count   = 0;
    wr_count      = 0;
    low_cycles    = 0;
    run_clk       = 1'b0;
    reset         = 1'b1;
    snes.addr     = '0;
    snes.read_n   = 1'b1;
    snes.write_n  = 1'b1;
    snes.romsel_n = 1'b1;
    snes.cpu_clk  = 1'b0;
    snes.din      = '0;
    mcu.rrq       = 1'b0;
    mcu.wrq       = 1'b0;
    mcu.addr      = '0;
    mcu.dout      = '0;
    rom_mask      = 24'h1FFFFF;
    saveram_mask  = 24'h01FFFF;
    rom_din       = '0;
    load_vectors();

    repeat (3) @(posedge CLK2);
    #10;
    reset = 1'b0;
    check_bit("mcu_rdy", mcu_rdy, 1'b1);
    check_bit("rom_we_n", rom_we_n, 1'b1);
    check_bit("rom_dout_en", rom_dout_en, 1'b0);
    check_bit("snes_dout_en", snes_dout_en, 1'b0);
    run_clk = 1'b1;

    for (int i = 0; i < NUM_VEC; i++) begin
      case (vectors[i].op)
        OP_SNES_RD: snes_read_op(vectors[i]);
        OP_SAVE_WR: saveram_write_op(vectors[i]);
        OP_MCU_RD:  mcu_read_op(vectors[i]);
        OP_MCU_WR:  mcu_write_op(vectors[i]);
        OP_REVIVE:  revive_op(vectors[i]);
        default: begin
          $display("Unknown operation in table entry %0d", i);
          errors++;
        end
      endcase
    end

    $display("Finished %0d table entries with %0d errors", NUM_VEC, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
cart_pkg.sv
snes_bus_sync.sv
snes_addr_map.sv
mcu_access_seq.sv
rom_port_mux.sv
cart_mem_ctrl.sv
tb_cart_mem_ctrl.sv
